// File: design/mon_cfg_pkg.sv
package mon_cfg_pkg;

  localparam int APB_ADDR_W = 16;
  localparam int APB_DATA_W = 32;
  localparam int AXI_ADDR_W = 64;
  localparam int AXI_ID_W   = 5;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_ID_W-1:0]   axi_id_t;

  // APB register map, byte offsets.
  localparam apb_addr_t REG_CTRL       = 16'h0000; // Bit 0 is enable.
  localparam apb_addr_t REG_USER_OUT   = 16'h0004;
  localparam apb_addr_t REG_USER_IN    = 16'h0008;
  localparam apb_addr_t REG_STATUS     = 16'h000C; // Write 1 to bit 0 to clear the log.
  localparam apb_addr_t REG_IRQ_THRESH = 16'h0010;
  localparam apb_addr_t REG_DROPS      = 16'h0014;
  localparam apb_addr_t LOG_BASE       = 16'h0100; // Log read window, 8 bytes per entry.

endpackage

// File: design/mon_log_pkg.sv
package mon_log_pkg;

  localparam int DEF_LOG_DEPTH_LOG2 = 4;

  typedef logic [31:0] log_addr_t;

  typedef struct packed {
    logic                  is_write;
    mon_cfg_pkg::axi_id_t  id;
    log_addr_t             addr;
  } log_entry_t;

  typedef logic [DEF_LOG_DEPTH_LOG2:0] log_ptr_t;

  // Word offsets within one 8-byte log entry.
  localparam int unsigned LOG_WORD_ADDR  = 0;
  localparam int unsigned LOG_WORD_INFO  = 1;
  localparam int unsigned INFO_WRITE_BIT = 8; // ID sits in the low bits of the info word.

endpackage

// File: design/log_wr_if.sv
`timescale 1ns/1ps

interface log_wr_if;

  logic                   req;
  mon_cfg_pkg::axi_id_t   id;
  mon_log_pkg::log_addr_t addr;
  logic                   drop; // One-cycle pulse per lost handshake.
  logic                   gnt;

  modport source (
    output req, id, addr, drop,
    input  gnt
  );

  modport sink (
    input  req, id, addr, drop,
    output gnt
  );

endinterface

// File: design/axi_addr_monitor.sv
`timescale 1ns/1ps

module axi_addr_monitor #(
  parameter int ID_START = 0,
  parameter int ID_END   = 31
) (
  input  logic                   aclk,
  input  logic                   reset,
  input  logic                   enable,
  input  logic                   valid,
  input  logic                   ready,
  input  mon_cfg_pkg::axi_id_t   id,
  input  mon_cfg_pkg::axi_addr_t addr,
  log_wr_if.source               log_port
);

  logic                   hit;
  logic                   buf_full;
  mon_cfg_pkg::axi_id_t   id_q;
  mon_log_pkg::log_addr_t addr_q;

  // Accepted handshake with an ID inside the configured window.
  assign hit = enable && valid && ready && (id >= ID_START) && (id <= ID_END);

  always_ff @(posedge aclk) begin
    if (reset) begin
      buf_full <= 1'b0;
    end else if (hit && !buf_full) begin
      buf_full <= 1'b1;
    end else if (buf_full && log_port.gnt) begin
      buf_full <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (hit && !buf_full) begin
      id_q   <= id;
      addr_q <= mon_log_pkg::log_addr_t'(addr); // Keep the low address bits only.
    end
  end

  assign log_port.req  = buf_full;
  assign log_port.id   = id_q;
  assign log_port.addr = addr_q;
  assign log_port.drop = hit && buf_full; // Buffer still occupied.

  // A pending request holds its payload until the log store takes it.
  a_req_stable : assert property (
    @(posedge aclk) disable iff (reset)
    log_port.req && !log_port.gnt |=>
      log_port.req && $stable(log_port.id) && $stable(log_port.addr)
  );

endmodule

// File: design/log_store.sv
`timescale 1ns/1ps

module log_store #(
  parameter int LOG_DEPTH_LOG2 = 4
) (
  input  logic                        aclk,
  input  logic                        reset,
  input  logic                        log_clear,
  log_wr_if.sink                      rd_port,
  log_wr_if.sink                      wr_port,
  output logic [LOG_DEPTH_LOG2:0]     fill,
  output logic                        overflow,
  output mon_cfg_pkg::apb_data_t      drops,
  input  logic [LOG_DEPTH_LOG2-1:0]   rd_index,
  output mon_log_pkg::log_entry_t     rd_entry
);

  localparam int DEPTH = 1 << LOG_DEPTH_LOG2;

  mon_log_pkg::log_entry_t mem [DEPTH];
  mon_log_pkg::log_entry_t new_entry;

  logic                   last_wr; // Write port was served last.
  logic                   gnt_rd;
  logic                   gnt_wr;
  logic                   any_gnt;
  logic                   full;
  logic [1:0]             drop_inc;
  logic [LOG_DEPTH_LOG2:0] fill_q;
  logic                   overflow_q;
  mon_cfg_pkg::apb_data_t drops_q;

  // Round robin: on a tie the port served last waits.
  assign gnt_rd  = rd_port.req && (!wr_port.req || last_wr);
  assign gnt_wr  = wr_port.req && (!rd_port.req || !last_wr);
  assign any_gnt = gnt_rd || gnt_wr;

  assign rd_port.gnt = gnt_rd;
  assign wr_port.gnt = gnt_wr;

  assign full = fill_q[LOG_DEPTH_LOG2];

  always_comb begin
    new_entry.is_write = gnt_wr;
    new_entry.id       = gnt_wr ? wr_port.id : rd_port.id;
    new_entry.addr     = gnt_wr ? wr_port.addr : rd_port.addr;
  end

  assign drop_inc = 2'(rd_port.drop) + 2'(wr_port.drop) + 2'(any_gnt && full);

  always_ff @(posedge aclk) begin
    if (reset) begin
      last_wr <= 1'b0;
    end else if (any_gnt) begin
      last_wr <= gnt_wr;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset || log_clear) begin
      fill_q     <= '0;
      overflow_q <= 1'b0;
      drops_q    <= '0;
    end else begin
      if (any_gnt && !full) begin
        fill_q <= fill_q + 1'b1;
      end
      if (any_gnt && full) begin
        overflow_q <= 1'b1; // Entry is discarded.
      end
      drops_q <= drops_q + drop_inc;
    end
  end

  always_ff @(posedge aclk) begin
    if (any_gnt && !full) begin
      mem[fill_q[LOG_DEPTH_LOG2-1:0]] <= new_entry;
    end
  end

  assign fill     = fill_q;
  assign overflow = overflow_q;
  assign drops    = drops_q;
  assign rd_entry = mem[rd_index];

  a_one_grant : assert property (
    @(posedge aclk) disable iff (reset) !(gnt_rd && gnt_wr)
  );

  a_fill_bound : assert property (
    @(posedge aclk) disable iff (reset) fill_q <= DEPTH
  );

endmodule

// File: design/apb_regs.sv
`timescale 1ns/1ps

module apb_regs #(
  parameter int LOG_DEPTH_LOG2 = 4
) (
  input  logic                        aclk,
  input  logic                        reset,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  mon_cfg_pkg::apb_addr_t      paddr,
  input  mon_cfg_pkg::apb_data_t      pwdata,
  output mon_cfg_pkg::apb_data_t      prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic                        pintreq,
  output mon_cfg_pkg::apb_data_t      user_out,
  input  mon_cfg_pkg::apb_data_t      user_in,
  output logic                        enable,
  output logic                        log_clear,
  input  logic [LOG_DEPTH_LOG2:0]     fill,
  input  logic                        overflow,
  input  mon_cfg_pkg::apb_data_t      drops,
  output logic [LOG_DEPTH_LOG2-1:0]   rd_index,
  input  mon_log_pkg::log_entry_t     rd_entry
);

  localparam mon_cfg_pkg::apb_addr_t WINDOW_BYTES =
    mon_cfg_pkg::apb_addr_t'((1 << LOG_DEPTH_LOG2) * 8);

  logic                   access;
  logic                   wr_en;
  logic                   reg_hit;
  logic                   in_window;
  logic                   slot_ok;
  mon_cfg_pkg::apb_addr_t log_off;
  mon_cfg_pkg::apb_data_t info_word;
  mon_cfg_pkg::apb_data_t status_word;
  mon_cfg_pkg::apb_data_t user_out_q;
  mon_cfg_pkg::apb_data_t thresh_q;
  logic                   enable_q;

  assign access = psel && penable;
  assign wr_en  = access && pwrite;

  always_ff @(posedge aclk) begin
    if (reset) begin
      enable_q   <= 1'b0;
      user_out_q <= '0;
      thresh_q   <= '0;
    end else if (wr_en) begin
      case (paddr)
        mon_cfg_pkg::REG_CTRL:       enable_q   <= pwdata[0];
        mon_cfg_pkg::REG_USER_OUT:   user_out_q <= pwdata;
        mon_cfg_pkg::REG_IRQ_THRESH: thresh_q   <= pwdata;
        default: ;
      endcase
    end
  end

  // Clear strobe acts on the log store at the access edge.
  assign log_clear = wr_en && (paddr == mon_cfg_pkg::REG_STATUS) && pwdata[0];

  // Log window decode.
  assign in_window = (paddr >= mon_cfg_pkg::LOG_BASE) &&
                     (paddr < mon_cfg_pkg::LOG_BASE + WINDOW_BYTES);
  assign log_off   = paddr - mon_cfg_pkg::LOG_BASE;
  assign rd_index  = log_off[LOG_DEPTH_LOG2+2:3];
  assign slot_ok   = in_window && ({1'b0, rd_index} < fill);

  always_comb begin
    info_word = '0;
    info_word[mon_log_pkg::INFO_WRITE_BIT] = rd_entry.is_write;
    info_word[mon_cfg_pkg::AXI_ID_W-1:0]   = rd_entry.id;
  end

  always_comb begin
    status_word = '0;
    status_word[15:0] = 16'(fill);
    status_word[16]   = overflow;
  end

  always_comb begin
    reg_hit = 1'b1;
    prdata  = '0;
    case (paddr)
      mon_cfg_pkg::REG_CTRL:       prdata = mon_cfg_pkg::apb_data_t'(enable_q);
      mon_cfg_pkg::REG_USER_OUT:   prdata = user_out_q;
      mon_cfg_pkg::REG_USER_IN:    prdata = user_in;
      mon_cfg_pkg::REG_STATUS:     prdata = status_word;
      mon_cfg_pkg::REG_IRQ_THRESH: prdata = thresh_q;
      mon_cfg_pkg::REG_DROPS:      prdata = drops;
      default:                     reg_hit = 1'b0;
    endcase
    if (slot_ok) begin
      prdata = (log_off[2] == 1'(mon_log_pkg::LOG_WORD_INFO)) ? info_word : rd_entry.addr;
    end
  end

  assign pready  = 1'b1; // Zero wait states.
  assign pslverr = access && (pwrite ? !reg_hit : !(reg_hit || slot_ok));

  assign pintreq = enable_q && (thresh_q != '0) &&
                   (mon_cfg_pkg::apb_data_t'(fill) >= thresh_q);

  assign user_out = user_out_q;
  assign enable   = enable_q;

  a_penable_psel : assert property (
    @(posedge aclk) disable iff (reset) penable |-> psel
  );

endmodule

// File: design/amba_monitor_top.sv
`timescale 1ns/1ps

module amba_monitor_top #(
  parameter int ID_START       = 0,
  parameter int ID_END         = 31,
  parameter int LOG_DEPTH_LOG2 = mon_log_pkg::DEF_LOG_DEPTH_LOG2
) (
  input  logic                   aclk,
  input  logic                   reset,

  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  mon_cfg_pkg::apb_addr_t paddr,
  input  mon_cfg_pkg::apb_data_t pwdata,
  output mon_cfg_pkg::apb_data_t prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   pintreq,

  output mon_cfg_pkg::apb_data_t ip_ctrl_write,
  input  mon_cfg_pkg::apb_data_t ip_ctrl_read,

  input  mon_cfg_pkg::axi_addr_t ip_araddr,
  input  mon_cfg_pkg::axi_id_t   ip_arid,
  input  logic                   ip_arvalid,
  output logic                   ip_arready,
  input  mon_cfg_pkg::axi_addr_t ip_awaddr,
  input  mon_cfg_pkg::axi_id_t   ip_awid,
  input  logic                   ip_awvalid,
  output logic                   ip_awready,

  output mon_cfg_pkg::axi_addr_t axi_araddr,
  output mon_cfg_pkg::axi_id_t   axi_arid,
  output logic                   axi_arvalid,
  input  logic                   axi_arready,
  output mon_cfg_pkg::axi_addr_t axi_awaddr,
  output mon_cfg_pkg::axi_id_t   axi_awid,
  output logic                   axi_awvalid,
  input  logic                   axi_awready
);

  logic                        enable;
  logic                        log_clear;
  logic [LOG_DEPTH_LOG2:0]     fill;
  logic                        overflow;
  mon_cfg_pkg::apb_data_t      drops;
  logic [LOG_DEPTH_LOG2-1:0]   rd_index;
  mon_log_pkg::log_entry_t     rd_entry;

  log_wr_if rd_log ();
  log_wr_if wr_log ();

  // Address channels pass straight through, no back-pressure added.
  assign axi_araddr  = ip_araddr;
  assign axi_arid    = ip_arid;
  assign axi_arvalid = ip_arvalid;
  assign ip_arready  = axi_arready;
  assign axi_awaddr  = ip_awaddr;
  assign axi_awid    = ip_awid;
  assign axi_awvalid = ip_awvalid;
  assign ip_awready  = axi_awready;

  axi_addr_monitor #(.ID_START(ID_START), .ID_END(ID_END)) u_rd_mon (
    .aclk(aclk), .reset(reset), .enable(enable),
    .valid(ip_arvalid), .ready(axi_arready), .id(ip_arid), .addr(ip_araddr),
    .log_port(rd_log)
  );

  axi_addr_monitor #(.ID_START(ID_START), .ID_END(ID_END)) u_wr_mon (
    .aclk(aclk), .reset(reset), .enable(enable),
    .valid(ip_awvalid), .ready(axi_awready), .id(ip_awid), .addr(ip_awaddr),
    .log_port(wr_log)
  );

  log_store #(.LOG_DEPTH_LOG2(LOG_DEPTH_LOG2)) u_store (
    .aclk(aclk), .reset(reset), .log_clear(log_clear),
    .rd_port(rd_log), .wr_port(wr_log),
    .fill(fill), .overflow(overflow), .drops(drops),
    .rd_index(rd_index), .rd_entry(rd_entry)
  );

  apb_regs #(.LOG_DEPTH_LOG2(LOG_DEPTH_LOG2)) u_regs (
    .aclk(aclk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .pintreq(pintreq),
    .user_out(ip_ctrl_write), .user_in(ip_ctrl_read),
    .enable(enable), .log_clear(log_clear),
    .fill(fill), .overflow(overflow), .drops(drops),
    .rd_index(rd_index), .rd_entry(rd_entry)
  );

endmodule

// File: tb/amba_monitor_tb.sv
`timescale 1ns/1ps

module amba_monitor_tb;

  localparam int ID_LO = 4;
  localparam int ID_HI = 23;
  localparam int DEPTH = 16;
  localparam int LIMIT = 100;

  logic                   aclk = 1'b0;
  logic                   reset = 1'b1;
  logic                   psel, penable, pwrite, pready, pslverr, pintreq;
  mon_cfg_pkg::apb_addr_t paddr;
  mon_cfg_pkg::apb_data_t pwdata, prdata, ip_ctrl_write, ip_ctrl_read;
  mon_cfg_pkg::axi_addr_t ip_araddr, ip_awaddr, axi_araddr, axi_awaddr;
  mon_cfg_pkg::axi_id_t   ip_arid, ip_awid, axi_arid, axi_awid;
  logic                   ip_arvalid, ip_arready, ip_awvalid, ip_awready;
  logic                   axi_arvalid, axi_arready, axi_awvalid, axi_awready;

  mon_log_pkg::log_entry_t exp_q[$]; // Expected log, in order of acceptance.
  mon_cfg_pkg::apb_data_t  exp_rd, alt_rd, rd_val, exp_thresh, exp_user;
  logic                    exp_enable, exp_err, chk_rd, use_alt, hold_ready, irq_exp;
  int                      errors, tests, failed_tests, test_errs;

  amba_monitor_top #(.ID_START(ID_LO), .ID_END(ID_HI), .LOG_DEPTH_LOG2(4)) DUT (.*);

  always #2 aclk = ~aclk;

  // Memory side back-pressure.
  always @(posedge aclk) begin
    axi_arready <= ($urandom % 2 == 1) || hold_ready;
    axi_awready <= ($urandom % 2 == 1) || hold_ready;
  end

  assign irq_exp = exp_enable && (exp_thresh != 0) && (32'(DUT.fill) >= exp_thresh);

  task automatic report_value(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
    $display("CHECK FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h",
             $time, name, exp, act);
    errors++;
  endtask

  a_ar_pass : assert property (@(posedge aclk)
    {axi_araddr, axi_arid, axi_arvalid, ip_arready} ==
    {ip_araddr, ip_arid, ip_arvalid, axi_arready})
    else report_value("axi_ar/ip_arready", $sampled({ip_araddr, ip_arid, ip_arvalid,
      axi_arready}), $sampled({axi_araddr, axi_arid, axi_arvalid, ip_arready}));

  a_aw_pass : assert property (@(posedge aclk)
    {axi_awaddr, axi_awid, axi_awvalid, ip_awready} ==
    {ip_awaddr, ip_awid, ip_awvalid, axi_awready})
    else report_value("axi_aw/ip_awready", $sampled({ip_awaddr, ip_awid, ip_awvalid,
      axi_awready}), $sampled({axi_awaddr, axi_awid, axi_awvalid, ip_awready}));

  a_irq : assert property (@(posedge aclk) disable iff (reset) pintreq == irq_exp)
    else report_value("pintreq", $sampled(irq_exp), $sampled(pintreq));

  a_rdata : assert property (@(posedge aclk) disable iff (reset)
    psel && penable && !pwrite && chk_rd |-> prdata == exp_rd || (use_alt && prdata == alt_rd))
    else report_value("prdata", $sampled(exp_rd), $sampled(prdata));

  a_resp : assert property (@(posedge aclk) disable iff (reset)
    psel && penable |-> pready && pslverr == exp_err)
    else report_value("pready/pslverr", {1'b1, $sampled(exp_err)},
                      $sampled({pready, pslverr}));

  a_user : assert property (@(posedge aclk) disable iff (reset) ip_ctrl_write == exp_user)
    else report_value("ip_ctrl_write", $sampled(exp_user), $sampled(ip_ctrl_write));

  task automatic abort_on_timeout(input string what);
    $display("Timeout waiting for %s", what);
    $display("Test failed");
    $finish;
  endtask

  // One APB transfer; data is the write data or the expected read data.
  task automatic apb_xfer(input logic wr, input mon_cfg_pkg::apb_addr_t addr,
                          input mon_cfg_pkg::apb_data_t data, input logic chk,
                          input logic err);
    @(posedge aclk);
    psel    <= 1'b1;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    exp_rd  <= data;
    chk_rd  <= chk;
    exp_err <= err;
    @(posedge aclk);
    penable <= 1'b1;
    @(negedge aclk);
    rd_val = prdata;
    @(posedge aclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    if (wr) begin
      case (addr)
        mon_cfg_pkg::REG_CTRL:       exp_enable <= data[0];
        mon_cfg_pkg::REG_USER_OUT:   exp_user   <= data;
        mon_cfg_pkg::REG_IRQ_THRESH: exp_thresh <= data;
        mon_cfg_pkg::REG_STATUS:     if (data[0]) exp_q.delete();
        default: ;
      endcase
    end
  endtask

  task automatic poll_reg(input mon_cfg_pkg::apb_addr_t addr,
                          input mon_cfg_pkg::apb_data_t value);
    int tries;
    tries  = 0;
    rd_val = ~value;
    while (rd_val != value && tries < LIMIT) begin
      apb_xfer(1'b0, addr, '0, 1'b0, 1'b0);
      tries++;
    end
    if (rd_val == value) begin
      apb_xfer(1'b0, addr, value, 1'b1, 1'b0);
    end else begin
      abort_on_timeout("an APB register value");
    end
  endtask

  task automatic log_expect(input logic is_wr, input mon_cfg_pkg::axi_id_t id,
                            input mon_cfg_pkg::axi_addr_t addr);
    mon_log_pkg::log_entry_t e;
    e.is_write = is_wr;
    e.id       = id;
    e.addr     = addr[31:0];
    if (exp_enable && id >= ID_LO && id <= ID_HI) begin
      exp_q.push_back(e);
    end
  endtask

  // AW carries the next ID up and the inverted address.
  task automatic send_addr(input logic ar, input logic aw, input mon_cfg_pkg::axi_id_t id,
                           input mon_cfg_pkg::axi_addr_t addr);
    int   cnt;
    logic ar_done;
    logic aw_done;
    ar_done = !ar;
    aw_done = !aw;
    cnt     = 0;
    @(posedge aclk);
    ip_arvalid <= ar;
    ip_arid    <= id;
    ip_araddr  <= addr;
    ip_awvalid <= aw;
    ip_awid    <= id + 5'd1;
    ip_awaddr  <= ~addr;
    while (!(ar_done && aw_done) && cnt < LIMIT) begin
      @(posedge aclk);
      if (ip_arvalid && ip_arready) begin
        ar_done = 1'b1;
        ip_arvalid <= 1'b0;
        log_expect(1'b0, ip_arid, ip_araddr);
      end
      if (ip_awvalid && ip_awready) begin
        aw_done = 1'b1;
        ip_awvalid <= 1'b0;
        log_expect(1'b1, ip_awid, ip_awaddr);
      end
      cnt++;
    end
    repeat (4) @(posedge aclk); // Monitor buffer drains.
    if (!(ar_done && aw_done)) begin
      abort_on_timeout("an AXI address handshake");
    end
  endtask

  function automatic mon_cfg_pkg::axi_id_t pick_in_range_id();
    return mon_cfg_pkg::axi_id_t'(ID_LO + $urandom % (ID_HI - ID_LO));
  endfunction

  function automatic mon_cfg_pkg::apb_data_t info_word_of(input mon_log_pkg::log_entry_t e);
    return {23'b0, e.is_write, 3'b0, e.id};
  endfunction

  task automatic check_slot(input int idx, input mon_log_pkg::log_entry_t e);
    mon_cfg_pkg::apb_addr_t a;
    a = mon_cfg_pkg::LOG_BASE + mon_cfg_pkg::apb_addr_t'(idx * 8);
    apb_xfer(1'b0, a, e.addr, 1'b1, 1'b0);
    apb_xfer(1'b0, a + 16'h4, info_word_of(e), 1'b1, 1'b0);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != test_errs) failed_tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_errs) ? "pass" : "errors");
    test_errs = errors;
  endtask

  initial begin
    bit                      r;
    int                      n;
    mon_cfg_pkg::axi_id_t    id;
    mon_cfg_pkg::apb_data_t  word;
    mon_log_pkg::log_entry_t p;
    mon_log_pkg::log_entry_t q;
    void'($urandom(37242));
    {psel, penable, pwrite, paddr, pwdata, ip_ctrl_read} = '0;
    {ip_arvalid, ip_arid, ip_araddr, ip_awvalid, ip_awid, ip_awaddr} = '0;
    {axi_arready, axi_awready, hold_ready} = '0;
    {exp_enable, exp_err, chk_rd, use_alt, exp_rd, alt_rd, exp_thresh, exp_user} = '0;
    {errors, tests, failed_tests, test_errs} = '0;
    repeat (8) @(posedge aclk);
    reset <= 1'b0;

    // Traffic with the monitor disabled.
    repeat (6) begin
      r = ($urandom % 2 == 1);
      send_addr(r, !r, 5'($urandom), {$urandom, $urandom});
    end
    poll_reg(mon_cfg_pkg::REG_STATUS, 32'h0);
    end_test("pass-through");

    apb_xfer(1'b1, mon_cfg_pkg::REG_IRQ_THRESH, 32'd3, 1'b0, 1'b0);
    apb_xfer(1'b1, mon_cfg_pkg::REG_CTRL, 32'd1, 1'b0, 1'b0);
    repeat (12) begin
      r = ($urandom % 2 == 1);
      send_addr(r, !r, 5'($urandom), {$urandom, $urandom});
    end
    poll_reg(mon_cfg_pkg::REG_STATUS, 32'(exp_q.size()));
    foreach (exp_q[i]) begin
      check_slot(i, exp_q[i]);
    end
    end_test("logging");

    n = exp_q.size();
    hold_ready <= 1'b1;
    repeat (2) @(posedge aclk);
    send_addr(1'b1, 1'b1, pick_in_range_id(), {$urandom, $urandom});
    hold_ready <= 1'b0;
    poll_reg(mon_cfg_pkg::REG_STATUS, 32'(n + 2));
    p = exp_q[n];
    q = exp_q[n + 1];
    alt_rd  = info_word_of(q);
    use_alt = 1'b1;
    apb_xfer(1'b0, mon_cfg_pkg::LOG_BASE + 16'(n * 8 + 4), info_word_of(p), 1'b1, 1'b0);
    use_alt = 1'b0;
    if (rd_val == info_word_of(q)) begin
      exp_q[n]     = q;
      exp_q[n + 1] = p;
    end
    check_slot(n, exp_q[n]);
    check_slot(n + 1, exp_q[n + 1]);
    end_test("concurrent AR and AW");

    apb_xfer(1'b1, mon_cfg_pkg::REG_STATUS, 32'd1, 1'b0, 1'b0);
    repeat (DEPTH + 3) begin
      r  = ($urandom % 2 == 1);
      id = pick_in_range_id();
      send_addr(r, !r, id, {$urandom, $urandom});
    end
    poll_reg(mon_cfg_pkg::REG_DROPS, 32'd3);
    poll_reg(mon_cfg_pkg::REG_STATUS, 32'h1_0000 | DEPTH); // Overflow in bit 16.
    apb_xfer(1'b1, mon_cfg_pkg::REG_STATUS, 32'd1, 1'b0, 1'b0);
    poll_reg(mon_cfg_pkg::REG_STATUS, 32'h0);
    poll_reg(mon_cfg_pkg::REG_DROPS, 32'h0);
    end_test("overflow and clear");

    repeat (2) begin
      send_addr(1'b1, 1'b0, pick_in_range_id(), {$urandom, $urandom});
    end
    poll_reg(mon_cfg_pkg::REG_STATUS, 32'd2);
    apb_xfer(1'b1, mon_cfg_pkg::REG_IRQ_THRESH, 32'd2, 1'b0, 1'b0);
    apb_xfer(1'b1, mon_cfg_pkg::REG_IRQ_THRESH, 32'd0, 1'b0, 1'b0);
    apb_xfer(1'b1, mon_cfg_pkg::REG_IRQ_THRESH, 32'd1, 1'b0, 1'b0);
    apb_xfer(1'b1, mon_cfg_pkg::REG_CTRL, 32'd0, 1'b0, 1'b0);
    end_test("interrupt");

    apb_xfer(1'b1, mon_cfg_pkg::REG_USER_OUT, $urandom, 1'b0, 1'b0);
    word = $urandom;
    ip_ctrl_read <= word;
    apb_xfer(1'b0, mon_cfg_pkg::REG_USER_IN, word, 1'b1, 1'b0);
    apb_xfer(1'b0, 16'h0040, 32'h0, 1'b0, 1'b1);
    apb_xfer(1'b1, 16'h0044, $urandom, 1'b0, 1'b1);
    apb_xfer(1'b0, mon_cfg_pkg::LOG_BASE + 16'h10, 32'h0, 1'b0, 1'b1); // Slot at fill.
    end_test("user registers and errors");

    $display("tests run %0d, tests with errors %0d, failed checks %0d",
             tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/mon_cfg_pkg.sv
design/mon_log_pkg.sv
design/log_wr_if.sv
design/axi_addr_monitor.sv
design/log_store.sv
design/apb_regs.sv
design/amba_monitor_top.sv
tb/amba_monitor_tb.sv

// File: Bender.yml
package:
  name: amba_monitor

sources:
  - design/mon_cfg_pkg.sv
  - design/mon_log_pkg.sv
  - design/log_wr_if.sv
  - design/axi_addr_monitor.sv
  - design/log_store.sv
  - design/apb_regs.sv
  - design/amba_monitor_top.sv
  - target: test
    files:
      - tb/amba_monitor_tb.sv
